// File: dcache_frontend.sv
module dcache_frontend
  import dcache_pkg::*;
#(
  parameter int NumPorts = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       flush_i,
  output logic                       flush_ack_o,

  // Core ports, the last one is the store port
  input  logic      [NumPorts-1:0]   core_req_valid_i,
  output logic      [NumPorts-1:0]   core_req_ready_o,
  input  core_req_t [NumPorts-1:0]   core_req_i,
  output logic      [NumPorts-1:0]   core_rsp_valid_o,
  output core_rsp_t [NumPorts-1:0]   core_rsp_o,

  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output mem_req_t                   mem_req_o,
  input  logic                       mem_rsp_valid_i,
  input  mem_rsp_t                   mem_rsp_i,

  input  logic                       hwpf_base_set_i,
  input  addr_t                      hwpf_base_i,
  input  logic                       hwpf_stride_set_i,
  input  addr_t                      hwpf_stride_i,
  input  logic                       hwpf_count_set_i,
  input  addr_t                      hwpf_count_i,
  output addr_t                      hwpf_base_o,
  output addr_t                      hwpf_stride_o,
  output addr_t                      hwpf_count_o,
  output logic                       hwpf_busy_o
);

  // Ports first, then the prefetcher
  localparam int NumRequesters = NumPorts + 1;

  logic      [NumRequesters-1:0] req_valid;
  logic      [NumRequesters-1:0] req_ready;
  mem_req_t  [NumRequesters-1:0] req;
  logic      [NumRequesters-1:0] rsp_valid;
  core_rsp_t                     rsp;
  logic                          snoop_valid;
  snoop_t                        snoop;
  logic                          flush_ack_q;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    req_port_adapter #(
      .SrcId(p)
    ) req_port_adapter_inst (
      .clk_i,
      .rst_ni,
      .core_req_valid_i(core_req_valid_i[p]),
      .core_req_ready_o(core_req_ready_o[p]),
      .core_req_i      (core_req_i[p]),
      .req_valid_o     (req_valid[p]),
      .req_ready_i     (req_ready[p]),
      .req_o           (req[p])
    );

    // Store acknowledge carries no data
    if (p == NumPorts - 1) begin : gen_store_rsp
      assign core_rsp_o[p] = '0;
    end else begin : gen_load_rsp
      assign core_rsp_o[p] = rsp;
    end
  end

  // Prefetch responses stay here
  assign core_rsp_valid_o = rsp_valid[NumPorts-1:0];

  // Snoop loads as they fire on the memory channel
  assign snoop_valid = mem_req_valid_o & mem_req_ready_i & (mem_req_o.op == OP_LOAD);
  assign snoop.addr = mem_req_o.addr;

  hwpf_stride #(
    .SrcId(NumPorts)
  ) hwpf_stride_inst (
    .clk_i,
    .rst_ni,
    .snoop_valid_i(snoop_valid),
    .snoop_i      (snoop),
    .base_set_i   (hwpf_base_set_i),
    .base_i       (hwpf_base_i),
    .stride_set_i (hwpf_stride_set_i),
    .stride_i     (hwpf_stride_i),
    .count_set_i  (hwpf_count_set_i),
    .count_i      (hwpf_count_i),
    .base_o       (hwpf_base_o),
    .stride_o     (hwpf_stride_o),
    .count_o      (hwpf_count_o),
    .busy_o       (hwpf_busy_o),
    .req_valid_o  (req_valid[NumPorts]),
    .req_ready_i  (req_ready[NumPorts]),
    .req_o        (req[NumPorts])
  );

  req_arbiter #(
    .NumRequesters(NumRequesters)
  ) req_arbiter_inst (
    .clk_i,
    .rst_ni,
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_i          (req),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_req_o      (mem_req_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_i      (mem_rsp_i),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp)
  );

  // Toggles while flush is held, one-cycle pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_ack_q <= 1'b0;
    end else begin
      flush_ack_q <= ~flush_ack_q & flush_i;
    end
  end

  assign flush_ack_o = flush_ack_q;

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SID_W = 3;

  // 16-byte lines
  localparam int LINE_OFFSET_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SID_W-1:0] sid_t;

  typedef enum logic [1:0] {
    OP_LOAD     = 2'd0,
    OP_STORE    = 2'd1,
    OP_PREFETCH = 2'd2
  } req_op_e;

  // Request as issued by a core port
  typedef struct packed {
    addr_t   addr;
    req_op_e op;
    data_t   wdata;
  } core_req_t;

  typedef struct packed {
    data_t rdata;
  } core_rsp_t;

  // Request on the shared memory channel, tagged with its source
  typedef struct packed {
    addr_t   addr;
    req_op_e op;
    sid_t    sid;
    data_t   wdata;
  } mem_req_t;

  typedef struct packed {
    sid_t  sid;
    data_t rdata;
  } mem_rsp_t;

  // Accepted load address seen by the prefetcher
  typedef struct packed {
    addr_t addr;
  } snoop_t;

endpackage

// File: hwpf_stride.sv
module hwpf_stride
  import dcache_pkg::*;
#(
  parameter int SrcId = 3
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     snoop_valid_i,
  input  snoop_t   snoop_i,

  input  logic     base_set_i,
  input  addr_t    base_i,
  input  logic     stride_set_i,
  input  addr_t    stride_i,
  input  logic     count_set_i,
  input  addr_t    count_i,

  output addr_t    base_o,
  output addr_t    stride_o,
  output addr_t    count_o,
  output logic     busy_o,

  output logic     req_valid_o,
  input  logic     req_ready_i,
  output mem_req_t req_o
);

  addr_t base_q;
  addr_t stride_q;
  addr_t count_q;
  logic  busy_q;
  addr_t remain_q;
  addr_t next_addr_q;
  logic  line_match;
  logic  start;
  logic  req_fire;
  logic  last_fire;

  assign line_match = snoop_i.addr[ADDR_W-1:LINE_OFFSET_W] == base_q[ADDR_W-1:LINE_OFFSET_W];

  // Zero count never triggers, snoops during a burst are ignored
  assign start = snoop_valid_i & line_match & ~busy_q & (count_q != '0);
  assign req_fire = busy_q & req_ready_i;
  assign last_fire = req_fire & (remain_q == addr_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q <= '0;
      stride_q <= '0;
      count_q <= '0;
      busy_q <= 1'b0;
      remain_q <= '0;
    end else begin
      if (start) begin
        busy_q <= 1'b1;
        remain_q <= count_q;
      end else if (last_fire) begin
        busy_q <= 1'b0;
        remain_q <= '0;
      end else if (req_fire) begin
        remain_q <= remain_q - 1'b1;
      end

      // Base follows the burst, so the next burst continues from there
      if (base_set_i) begin
        base_q <= base_i;
      end else if (last_fire) begin
        base_q <= next_addr_q;
      end
      if (stride_set_i) begin
        stride_q <= stride_i;
      end
      if (count_set_i) begin
        count_q <= count_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      next_addr_q <= base_q + stride_q;
    end else if (req_fire) begin
      next_addr_q <= next_addr_q + stride_q;
    end
  end

  assign req_valid_o = busy_q;
  assign req_o.addr = next_addr_q;
  assign req_o.op = OP_PREFETCH;
  assign req_o.sid = sid_t'(SrcId);
  assign req_o.wdata = '0;

  assign base_o = base_q;
  assign stride_o = stride_q;
  assign count_o = count_q;
  assign busy_o = busy_q;

endmodule

// File: req_arbiter.sv
module req_arbiter
  import dcache_pkg::*;
#(
  parameter int NumRequesters = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  input  logic       [NumRequesters-1:0]     req_valid_i,
  output logic       [NumRequesters-1:0]     req_ready_o,
  input  mem_req_t   [NumRequesters-1:0]     req_i,

  output logic                               mem_req_valid_o,
  input  logic                               mem_req_ready_i,
  output mem_req_t                           mem_req_o,

  input  logic                               mem_rsp_valid_i,
  input  mem_rsp_t                           mem_rsp_i,

  output logic       [NumRequesters-1:0]     rsp_valid_o,
  output core_rsp_t                          rsp_o
);

  localparam int IdxW = $clog2(NumRequesters);

  logic [IdxW-1:0] prio_q;
  logic [IdxW-1:0] gnt_idx;
  logic            gnt_found;
  logic            mem_fire;

  // First valid requester at or after the priority pointer
  always_comb begin
    int idx;
    gnt_idx = '0;
    gnt_found = 1'b0;
    for (int k = 0; k < NumRequesters; k++) begin
      idx = (int'(prio_q) + k) % NumRequesters;
      if (!gnt_found && req_valid_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx = IdxW'(idx);
      end
    end
  end

  assign mem_req_valid_o = gnt_found;
  assign mem_req_o = req_i[gnt_idx];
  assign mem_fire = gnt_found & mem_req_ready_i;

  // Only the winner sees ready, and only when memory takes it
  always_comb begin
    for (int r = 0; r < NumRequesters; r++) begin
      req_ready_o[r] = mem_fire && (gnt_idx == IdxW'(r));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else if (mem_fire) begin
      if (gnt_idx == IdxW'(NumRequesters - 1)) begin
        prio_q <= '0;
      end else begin
        prio_q <= gnt_idx + 1'b1;
      end
    end
  end

  // Response goes back to the requester named by its sid
  always_comb begin
    for (int r = 0; r < NumRequesters; r++) begin
      rsp_valid_o[r] = mem_rsp_valid_i && (mem_rsp_i.sid == sid_t'(r));
    end
  end

  assign rsp_o.rdata = mem_rsp_i.rdata;

endmodule

// File: req_port_adapter.sv
module req_port_adapter
  import dcache_pkg::*;
#(
  parameter int SrcId = 0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      core_req_valid_i,
  output logic      core_req_ready_o,
  input  core_req_t core_req_i,

  output logic      req_valid_o,
  input  logic      req_ready_i,
  output mem_req_t  req_o
);

  logic     full_q;
  mem_req_t req_q;
  mem_req_t req_d;
  logic     core_fire;

  // Accept when empty or when the held entry leaves this cycle
  assign core_req_ready_o = ~full_q | req_ready_i;
  assign core_fire = core_req_valid_i & core_req_ready_o;

  // Tag with the source id, only stores carry data
  always_comb begin
    req_d.addr = core_req_i.addr;
    req_d.op = core_req_i.op;
    req_d.sid = sid_t'(SrcId);
    if (core_req_i.op == OP_STORE) begin
      req_d.wdata = core_req_i.wdata;
    end else begin
      req_d.wdata = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (core_fire) begin
      full_q <= 1'b1;
    end else if (req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_fire) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = full_q;
  assign req_o = req_q;

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_dcache_frontend -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_dcache_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

// File: src.f
dcache_pkg.sv
req_port_adapter.sv
req_arbiter.sv
hwpf_stride.sv
dcache_frontend.sv
tb_mem_model.sv
tb_dcache_frontend.sv

// File: tb_dcache_frontend.sv
module tb_dcache_frontend
  import dcache_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumPorts = 3;
  localparam int Timeout = 200;
  localparam data_t Mask = 32'hA5A5A5A5;
  localparam addr_t PfBase = 32'h0000_8000;
  localparam addr_t PfStride = 32'h0000_0040;
  localparam addr_t PfCount = 32'd3;

  // One request of the stimulus table; equal grp values issue together
  typedef struct packed {
    logic [3:0] grp;
    logic [1:0] port;
    req_op_e    op;
    addr_t      addr;
    data_t      wdata;
    data_t      exp;
  } vec_t;

  localparam int NumVecs = 12;
  vec_t vecs [NumVecs] = '{
    '{4'd0, 2'd0, OP_LOAD, 32'h0000_1000, 32'h0, 32'h0000_1000 ^ Mask},
    '{4'd1, 2'd1, OP_LOAD, 32'h0000_2004, 32'h0, 32'h0000_2004 ^ Mask},
    '{4'd2, 2'd2, OP_STORE, 32'h0000_3000, 32'hDEADBEEF, 32'h0},
    '{4'd3, 2'd0, OP_LOAD, 32'h0000_3000, 32'h0, 32'hDEADBEEF},
    '{4'd4, 2'd0, OP_LOAD, 32'h0000_4000, 32'h0, 32'h0000_4000 ^ Mask},
    '{4'd4, 2'd1, OP_LOAD, 32'h0000_3000, 32'h0, 32'hDEADBEEF},
    '{4'd4, 2'd2, OP_STORE, 32'h0000_5000, 32'h12345678, 32'h0},
    '{4'd5, 2'd0, OP_LOAD, 32'h0000_5000, 32'h0, 32'h12345678},
    '{4'd5, 2'd1, OP_LOAD, 32'h0000_4008, 32'h0, 32'h0000_4008 ^ Mask},
    '{4'd5, 2'd2, OP_STORE, 32'h0000_3000, 32'hCAFEF00D, 32'h0},
    '{4'd6, 2'd1, OP_LOAD, 32'h0000_3000, 32'h0, 32'hCAFEF00D},
    '{4'd7, 2'd0, OP_LOAD, PfBase, 32'h0, PfBase ^ Mask}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  logic                     flush_ack;
  logic      [NumPorts-1:0] core_req_valid;
  logic      [NumPorts-1:0] core_req_ready;
  core_req_t [NumPorts-1:0] core_req;
  logic      [NumPorts-1:0] core_rsp_valid;
  core_rsp_t [NumPorts-1:0] core_rsp;
  logic                     mem_req_valid;
  logic                     mem_req_ready;
  mem_req_t                 mem_req;
  logic                     mem_rsp_valid;
  mem_rsp_t                 mem_rsp;
  logic                     hwpf_base_set;
  logic                     hwpf_stride_set;
  logic                     hwpf_count_set;
  addr_t                    hwpf_base;
  addr_t                    hwpf_stride;
  addr_t                    hwpf_count;
  addr_t                    hwpf_base_q;
  addr_t                    hwpf_stride_q;
  addr_t                    hwpf_count_q;
  logic                     hwpf_busy;
  int                       errors = 0;
  int                       nchecks = 0;

  dcache_frontend #(
    .NumPorts(NumPorts)
  ) dcache_frontend_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .flush_i          (flush),
    .flush_ack_o      (flush_ack),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_req_i       (core_req),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_o       (core_rsp),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_o        (mem_req),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .mem_rsp_i        (mem_rsp),
    .hwpf_base_set_i  (hwpf_base_set),
    .hwpf_base_i      (hwpf_base),
    .hwpf_stride_set_i(hwpf_stride_set),
    .hwpf_stride_i    (hwpf_stride),
    .hwpf_count_set_i (hwpf_count_set),
    .hwpf_count_i     (hwpf_count),
    .hwpf_base_o      (hwpf_base_q),
    .hwpf_stride_o    (hwpf_stride_q),
    .hwpf_count_o     (hwpf_count_q),
    .hwpf_busy_o      (hwpf_busy)
  );

  tb_mem_model mem_model_inst (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .mem_req_valid_i(mem_req_valid),
    .mem_req_ready_o(mem_req_ready),
    .mem_req_i      (mem_req),
    .mem_rsp_valid_o(mem_rsp_valid),
    .mem_rsp_o      (mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    nchecks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // No core response may show up in this window
  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      check("idle responses", 32'd0, 32'(core_rsp_valid));
      @(negedge clk);
    end
  endtask

  // Issue each group of table entries together, called on a falling edge
  task automatic apply_groups(input int g_first, input int g_last);
    logic [NumPorts-1:0] pend_req;
    logic [NumPorts-1:0] pend_rsp;
    int                  vec_of [NumPorts];
    int                  cyc;
    int                  p;
    for (int g = g_first; g <= g_last; g++) begin
      pend_req = '0;
      for (int i = 0; i < NumVecs; i++) begin
        if (int'(vecs[i].grp) == g) begin
          p = int'(vecs[i].port);
          vec_of[p] = i;
          pend_req[p] = 1'b1;
          core_req[p].addr = vecs[i].addr;
          core_req[p].op = vecs[i].op;
          core_req[p].wdata = vecs[i].wdata;
        end
      end
      pend_rsp = pend_req;
      core_req_valid = pend_req;
      cyc = 0;
      while ((pend_req | pend_rsp) != '0 && cyc < Timeout) begin
        @(posedge clk);
        for (int q = 0; q < NumPorts; q++) begin
          if (core_rsp_valid[q]) begin
            if (pend_rsp[q] && !pend_req[q]) begin
              check($sformatf("vector %0d port %0d", vec_of[q], q),
                    vecs[vec_of[q]].exp, core_rsp[q].rdata);
              pend_rsp[q] = 1'b0;
            end else begin
              errors++;
              $display("Unexpected response on port %0d in group %0d", q, g);
            end
          end
          if (pend_req[q] && core_req_ready[q]) begin
            pend_req[q] = 1'b0;
          end
        end
        @(negedge clk);
        core_req_valid = pend_req;
        cyc++;
      end
      if ((pend_req | pend_rsp) != '0) begin
        errors++;
        $display("Timeout in group %0d, ports still waiting: %b", g, pend_req | pend_rsp);
      end
      core_req_valid = '0;
      expect_idle(4);
    end
  endtask

  initial begin
    int log_start;
    int n_pf;
    int cyc;
    rst_n = 1'b0;
    flush = 1'b0;
    core_req_valid = '0;
    core_req = '0;
    hwpf_base_set = 1'b0;
    hwpf_stride_set = 1'b0;
    hwpf_count_set = 1'b0;
    hwpf_base = '0;
    hwpf_stride = '0;
    hwpf_count = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check("reset mem_req_valid", 32'd0, 32'(mem_req_valid));
    check("reset core_rsp_valid", 32'd0, 32'(core_rsp_valid));
    check("reset hwpf_busy", 32'd0, 32'(hwpf_busy));
    check("reset flush_ack", 32'd0, 32'(flush_ack));
    check("reset core_req_ready", 32'((1 << NumPorts) - 1), 32'(core_req_ready));

    // Single loads, store then load, concurrent traffic
    apply_groups(0, 6);

    hwpf_base = PfBase;
    hwpf_stride = PfStride;
    hwpf_count = PfCount;
    hwpf_base_set = 1'b1;
    hwpf_stride_set = 1'b1;
    hwpf_count_set = 1'b1;
    @(negedge clk);
    hwpf_base_set = 1'b0;
    hwpf_stride_set = 1'b0;
    hwpf_count_set = 1'b0;
    check("hwpf stride", PfStride, hwpf_stride_q);
    check("hwpf count", PfCount, hwpf_count_q);

    // Load of the base line starts the burst
    log_start = mem_model_inst.log_cnt;
    apply_groups(7, 7);
    cyc = 0;
    while (hwpf_busy && cyc < Timeout) begin
      @(negedge clk);
      cyc++;
    end
    if (hwpf_busy) begin
      errors++;
      $display("Timeout waiting for the prefetch burst to end");
    end
    n_pf = 0;
    for (int i = log_start; i < mem_model_inst.log_cnt && i < 256; i++) begin
      if (mem_model_inst.log_q[i].op == OP_PREFETCH) begin
        n_pf++;
        check($sformatf("prefetch %0d addr", n_pf), PfBase + addr_t'(n_pf) * PfStride,
              mem_model_inst.log_q[i].addr);
        check($sformatf("prefetch %0d sid", n_pf), 32'(NumPorts),
              32'(mem_model_inst.log_q[i].sid));
      end
    end
    check("prefetch count", PfCount, 32'(n_pf));
    check("hwpf base after burst", PfBase + PfCount * PfStride, hwpf_base_q);

    // Flush held for one cycle
    flush = 1'b1;
    @(posedge clk);
    check("flush ack before edge", 32'd0, 32'(flush_ack));
    @(negedge clk);
    flush = 1'b0;
    @(posedge clk);
    check("flush ack pulse", 32'd1, 32'(flush_ack));
    @(posedge clk);
    check("flush ack after pulse", 32'd0, 32'(flush_ack));
    @(negedge clk);

    $display("Checks: %0d, errors: %0d", nchecks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb_mem_model.sv
module tb_mem_model
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     mem_req_valid_i,
  output logic     mem_req_ready_o,
  input  mem_req_t mem_req_i,
  output logic     mem_rsp_valid_o,
  output mem_rsp_t mem_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int       seed = 82512;
  data_t    mem_q [addr_t];
  mem_rsp_t rsp_q [$];
  int       delay_q [$];
  // Every accepted request in arrival order
  mem_req_t log_q [256];
  int       log_cnt = 0;

  initial begin
    mem_req_ready_o = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_o = '0;
  end

  // Accept a request and queue its answer
  always @(posedge clk_i) begin
    data_t rdata;
    if (rst_ni && mem_req_valid_i && mem_req_ready_o) begin
      if (log_cnt < 256) begin
        log_q[log_cnt] = mem_req_i;
      end
      log_cnt++;
      if (mem_req_i.op == OP_STORE) begin
        mem_q[mem_req_i.addr] = mem_req_i.wdata;
        // A store answers with its own data on the bus
        rdata = mem_req_i.wdata;
      end else if (mem_q.exists(mem_req_i.addr)) begin
        rdata = mem_q[mem_req_i.addr];
      end else begin
        // Never written, so the word is made from its address
        rdata = mem_req_i.addr ^ 32'hA5A5A5A5;
      end
      rsp_q.push_back({mem_req_i.sid, rdata});
      delay_q.push_back(int'({$random(seed)} % 4));
    end
  end

  // Random back-pressure and in-order answers
  always @(negedge clk_i) begin
    mem_rsp_valid_o = 1'b0;
    mem_req_ready_o = ($random(seed) & 3) != 0;
    if (rsp_q.size() > 0) begin
      if (delay_q[0] == 0) begin
        mem_rsp_o = rsp_q.pop_front();
        void'(delay_q.pop_front());
        mem_rsp_valid_o = 1'b1;
      end else begin
        delay_q[0] = delay_q[0] - 1;
      end
    end
  end

endmodule
